// File: hw/rtg_pkg.sv
// RTG video path shared definitions
`default_nettype none

package rtg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W      = 25;                  // Byte address into SDRAM space
  localparam int WORD_W      = 16;                  // One hi-colour pixel
  localparam int COLOR_W     = 8;                   // Per channel on the VGA side
  localparam int BURST_LEN   = 4;                   // Words per memory fill
  localparam int BURST_BYTES = 8;                   // BURST_LEN words of two bytes
  localparam int FIFO_DEPTH  = 16;                  // Line buffer entries
  localparam int PIXCNT_W    = 4;                   // Clocks-per-pixel counter
  localparam int VBCNT_W     = 7;                   // Blank extension lines

  localparam int BURST_CNT_W = $clog2(BURST_LEN);   // Fill counter
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);  // FIFO pointers
  localparam int LEVEL_W     = FIFO_PTR_W + 1;      // Holds 0 to FIFO_DEPTH

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]   addr_t;        // Byte address
  typedef logic [WORD_W-1:0]   word_t;        // RGB555 pixel word
  typedef logic [COLOR_W-1:0]  color_t;       // One expanded channel
  typedef logic [PIXCNT_W-1:0] pixcnt_t;      // Clocks per pixel minus one
  typedef logic [VBCNT_W-1:0]  vbcnt_t;       // Lines after vblank
  typedef logic [LEVEL_W-1:0]  fifo_level_t;  // FIFO fill or free count

  // Burst request FSM
  typedef enum logic {
    FETCH_IDLE,       // Free to issue next burst
    FETCH_WAIT_FILL   // One request outstanding
  } fetch_state_t;

endpackage

`default_nettype wire

// File: hw/rtg_stream_if.sv
// Pixel word stream between fetch, FIFO and pixel stage
`timescale 1ns/1ns
`default_nettype none

interface rtg_stream_if (
  input wire clk_114
);

  logic                 push;       // Write strobe, one word per cycle
  rtg_pkg::word_t       push_data;  // Word written on push
  rtg_pkg::fifo_level_t space;      // Free FIFO slots
  logic                 pop;        // Remove head word
  rtg_pkg::word_t       pop_data;   // Head word, valid the edge after pop
  logic                 flush;      // Empties FIFO while high

  // Fetch engine side
  modport producer (
    input  clk_114,
    output push,
    output push_data,
    output flush,
    input  space
  );

  // Line FIFO
  modport buffer (
    input  clk_114,
    input  push,
    input  push_data,
    input  pop,
    input  flush,
    output space,
    output pop_data
  );

  // Pixel stage side
  modport consumer (
    input  clk_114,
    output pop,
    input  pop_data
  );

endinterface

`default_nettype wire

// File: hw/rtg_fetch.sv
// RTG burst fetch engine
`timescale 1ns/1ns
`default_nettype none

module rtg_fetch (
  input  wire                   clk_114,
  input  wire                   arst_n,
  input  wire                   rtg_ena,    // RTG screen on
  input  wire                   vblank,     // Chipset vertical blank
  input  wire  rtg_pkg::addr_t  base_addr,  // Frame buffer start
  input  wire                   mem_fill,   // One word back from memory
  input  wire  rtg_pkg::word_t  mem_data,
  output logic                  mem_req,    // Single-cycle burst request
  output rtg_pkg::addr_t        mem_addr,   // Mangled burst address
  rtg_stream_if.producer        stream
);

  rtg_pkg::fetch_state_t              state;
  rtg_pkg::addr_t                     next_addr;   // Linear address of next burst
  logic [rtg_pkg::BURST_CNT_W-1:0]    fill_cnt;    // Words returned so far
  logic                               discard;     // Burst aborted by restart
  logic                               restart;
  logic                               last_fill;
  rtg_pkg::fifo_level_t               room_need;   // Slots needed before request

  assign restart   = vblank | ~rtg_ena;          // Rewind at each frame or when off
  assign last_fill = mem_fill && (fill_cnt == rtg_pkg::BURST_CNT_W'(rtg_pkg::BURST_LEN - 1));

  // A push still in flight has not reached the FIFO level yet
  assign room_need = rtg_pkg::fifo_level_t'(rtg_pkg::BURST_LEN)
                   + rtg_pkg::fifo_level_t'(stream.push);

  // CPU address map, bit 23 flips above 2MB within each 8MB
  assign mem_addr = {next_addr[24], next_addr[23] ^ (next_addr[22] | next_addr[21]),
                     next_addr[22:0]};

  //////////////////////////////////////////////////////////////////////
  // Request FSM and address counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      state        <= rtg_pkg::FETCH_IDLE;
      next_addr    <= '0;
      fill_cnt     <= '0;
      discard      <= 1'b0;
      mem_req      <= 1'b0;
      stream.flush <= 1'b0;
    end else begin
      mem_req      <= 1'b0;                      // Strobe only
      stream.flush <= restart;                   // Drop buffered line on rewind
      if (restart) begin
        next_addr <= {base_addr[rtg_pkg::ADDR_W-1:4], 4'b0000};  // Align to 16 bytes
      end
      case (state)
        rtg_pkg::FETCH_IDLE: begin
          if (!restart && stream.space >= room_need) begin
            mem_req  <= 1'b1;
            fill_cnt <= '0;
            discard  <= 1'b0;
            state    <= rtg_pkg::FETCH_WAIT_FILL;
          end
        end
        rtg_pkg::FETCH_WAIT_FILL: begin
          if (restart) begin
            discard <= 1'b1;                     // Let the burst drain unused
          end
          if (mem_fill) begin
            fill_cnt <= fill_cnt + 1'b1;
          end
          if (last_fill) begin
            state <= rtg_pkg::FETCH_IDLE;
            if (!restart && !discard) begin
              next_addr <= next_addr + rtg_pkg::addr_t'(rtg_pkg::BURST_BYTES);
            end
          end
        end
        default: state <= rtg_pkg::FETCH_IDLE;
      endcase
    end
  end

  // Fill capture, pushed one cycle after mem_fill
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      stream.push <= 1'b0;
    end else begin
      stream.push <= mem_fill && !restart && !discard
                     && (state == rtg_pkg::FETCH_WAIT_FILL);
    end
  end

  always_ff @(posedge clk_114) begin
    if (mem_fill) begin
      stream.push_data <= mem_data;              // Payload only
    end
  end

  // FIFO must have room for every pushed word
  a_push_room: assert property (@(posedge clk_114) disable iff (!arst_n)
    stream.push |-> stream.space != '0)
    else $error("rtg_fetch: push into full FIFO");

  // Memory answers only an outstanding request
  a_fill_idle: assert property (@(posedge clk_114) disable iff (!arst_n)
    mem_fill |-> state == rtg_pkg::FETCH_WAIT_FILL)
    else $error("rtg_fetch: mem_fill with no request outstanding");

endmodule

`default_nettype wire

// File: hw/rtg_line_fifo.sv
// RTG line buffer FIFO
`timescale 1ns/1ns
`default_nettype none

module rtg_line_fifo (
  input  wire           clk_114,
  input  wire           arst_n,
  rtg_stream_if.buffer  stream
);

  rtg_pkg::word_t                   mem [rtg_pkg::FIFO_DEPTH];  // Word storage
  logic [rtg_pkg::FIFO_PTR_W-1:0]   wr_ptr;
  logic [rtg_pkg::FIFO_PTR_W-1:0]   rd_ptr;
  rtg_pkg::fifo_level_t             level;     // Words held
  logic                             do_push;
  logic                             do_pop;

  // Flush overrides both sides
  assign do_push = stream.push & ~stream.flush;
  assign do_pop  = stream.pop & ~stream.flush;

  assign stream.space = rtg_pkg::fifo_level_t'(rtg_pkg::FIFO_DEPTH) - level;

  //////////////////////////////////////////////////////////////////////
  // Pointers and level
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (stream.flush) begin
      wr_ptr <= '0;                              // Back to empty
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;                 // Wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;                 // Both or neither
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_114) begin
    if (do_push) begin
      mem[wr_ptr] <= stream.push_data;
    end
  end

  // Head word held until next pop
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      stream.pop_data <= '0;
    end else if (do_pop) begin
      stream.pop_data <= mem[rd_ptr];
    end
  end

  // Pixel stage must never underrun the line buffer
  a_pop_empty: assert property (@(posedge clk_114) disable iff (!arst_n)
    do_pop |-> level != '0)
    else $error("rtg_line_fifo: pop while empty");

endmodule

`default_nettype wire

// File: hw/rtg_pixel_out.sv
// RTG pixel pacing, colour select and OSD overlay
`timescale 1ns/1ns
`default_nettype none

module rtg_pixel_out (
  input  wire                    clk_114,
  input  wire                    arst_n,
  input  wire                    rtg_ena,      // RTG screen on
  input  wire  rtg_pkg::pixcnt_t pixel_width,  // Clocks per pixel minus one
  input  wire  rtg_pkg::vbcnt_t  vb_end,       // Extra blank lines after vblank
  input  wire                    hblank,
  input  wire                    vblank,
  input  wire                    native_hs,    // Chipset syncs
  input  wire                    native_vs,
  input  wire  rtg_pkg::color_t  native_r,     // Chipset colour
  input  wire  rtg_pkg::color_t  native_g,
  input  wire  rtg_pkg::color_t  native_b,
  input  wire                    osd_window,   // Inside OSD box
  input  wire                    osd_pixel,    // OSD foreground
  output rtg_pkg::color_t        vga_r,
  output rtg_pkg::color_t        vga_g,
  output rtg_pkg::color_t        vga_b,
  output logic                   vga_hs,
  output logic                   vga_vs,
  rtg_stream_if.consumer         stream
);

  logic              hs_d;          // For hsync edge
  logic              rtg_vblank;    // Extended vertical blank
  rtg_pkg::vbcnt_t   vb_cnt;        // Lines since vblank
  rtg_pkg::pixcnt_t  pix_cnt;       // Clocks into current pixel
  logic              blank;
  logic              blank_d;
  logic              blank_d2;      // Lines up with pop_data
  logic              use_rtg;
  rtg_pkg::color_t   rtg_r, rtg_g, rtg_b;
  rtg_pkg::color_t   sel_r, sel_g, sel_b;
  logic [1:0]        osd_r, osd_g, osd_b;

  // Five bits widen by repeating the top three below them
  function automatic rtg_pkg::color_t expand5(input logic [4:0] c);
    return {c, c[4:2]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Blank extension
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      hs_d       <= 1'b0;
      rtg_vblank <= 1'b1;                        // Start blanked
      vb_cnt     <= '0;
    end else begin
      hs_d <= native_hs;
      if (vblank) begin
        rtg_vblank <= 1'b1;
        vb_cnt     <= '0;
      end else if (vb_cnt == vb_end) begin
        rtg_vblank <= 1'b0;                      // Enough lines skipped
      end else if (native_hs && !hs_d) begin
        vb_cnt <= vb_cnt + 1'b1;                 // One per line
      end
    end
  end

  assign blank = rtg_vblank | hblank;

  //////////////////////////////////////////////////////////////////////
  // Pixel pacing
  //////////////////////////////////////////////////////////////////////

  assign stream.pop = rtg_ena && !blank && (pix_cnt == pixel_width);

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt  <= '0;
      blank_d  <= 1'b1;
      blank_d2 <= 1'b1;
    end else begin
      blank_d  <= blank;
      blank_d2 <= blank_d;
      if (blank || stream.pop) begin
        pix_cnt <= '0;                           // Restart each pixel
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // RGB555 unpack, bit 15 unused
  assign rtg_r = expand5(stream.pop_data[14:10]);
  assign rtg_g = expand5(stream.pop_data[9:5]);
  assign rtg_b = expand5(stream.pop_data[4:0]);

  //////////////////////////////////////////////////////////////////////
  // Video select and OSD
  //////////////////////////////////////////////////////////////////////

  assign use_rtg = rtg_ena & ~blank_d2;
  assign sel_r   = use_rtg ? rtg_r : native_r;
  assign sel_g   = use_rtg ? rtg_g : native_g;
  assign sel_b   = use_rtg ? rtg_b : native_b;

  assign osd_r = osd_pixel ? 2'b11 : 2'b00;      // White text
  assign osd_g = osd_pixel ? 2'b11 : 2'b00;
  assign osd_b = osd_pixel ? 2'b11 : 2'b10;      // Over dark blue

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b0;
      vga_vs <= 1'b0;
    end else begin
      vga_r  <= osd_window ? {osd_r, sel_r[7:2]} : sel_r;  // Dim under OSD
      vga_g  <= osd_window ? {osd_g, sel_g[7:2]} : sel_g;
      vga_b  <= osd_window ? {osd_b, sel_b[7:2]} : sel_b;
      vga_hs <= native_hs;
      vga_vs <= native_vs;
    end
  end

endmodule

`default_nettype wire

// File: hw/rtg_video_top.sv
// RTG video path top level
`timescale 1ns/1ns
`default_nettype none

module rtg_video_top (
  input  wire                    clk_114,
  input  wire                    arst_n,
  input  wire                    rtg_ena,
  input  wire  rtg_pkg::addr_t   base_addr,
  input  wire  rtg_pkg::pixcnt_t pixel_width,
  input  wire  rtg_pkg::vbcnt_t  vb_end,
  input  wire                    hblank,
  input  wire                    vblank,
  input  wire                    native_hs,
  input  wire                    native_vs,
  input  wire  rtg_pkg::color_t  native_r,
  input  wire  rtg_pkg::color_t  native_g,
  input  wire  rtg_pkg::color_t  native_b,
  input  wire                    osd_window,
  input  wire                    osd_pixel,
  input  wire                    mem_fill,
  input  wire  rtg_pkg::word_t   mem_data,
  output wire                    mem_req,
  output rtg_pkg::addr_t         mem_addr,
  output rtg_pkg::color_t        vga_r,
  output rtg_pkg::color_t        vga_g,
  output rtg_pkg::color_t        vga_b,
  output wire                    vga_hs,
  output wire                    vga_vs
);

  // Fetch to FIFO to pixel stage
  rtg_stream_if stream_if (.clk_114(clk_114));

  rtg_fetch rtg_fetch_i (
    .clk_114   (clk_114),
    .arst_n    (arst_n),
    .rtg_ena   (rtg_ena),
    .vblank    (vblank),
    .base_addr (base_addr),
    .mem_fill  (mem_fill),
    .mem_data  (mem_data),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .stream    (stream_if.producer)
  );

  rtg_line_fifo rtg_line_fifo_i (
    .clk_114 (clk_114),
    .arst_n  (arst_n),
    .stream  (stream_if.buffer)
  );

  rtg_pixel_out rtg_pixel_out_i (
    .clk_114     (clk_114),
    .arst_n      (arst_n),
    .rtg_ena     (rtg_ena),
    .pixel_width (pixel_width),
    .vb_end      (vb_end),
    .hblank      (hblank),
    .vblank      (vblank),
    .native_hs   (native_hs),
    .native_vs   (native_vs),
    .native_r    (native_r),
    .native_g    (native_g),
    .native_b    (native_b),
    .osd_window  (osd_window),
    .osd_pixel   (osd_pixel),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .stream      (stream_if.consumer)
  );

endmodule

`default_nettype wire

// File: dv/rtg_mem_model.sv
// Testbench memory for the RTG fetch port
`timescale 1ns/1ns
`default_nettype none

module rtg_mem_model (
  input  wire                  clk_114,
  input  wire                  arst_n,
  input  wire                  mem_req,    // One-cycle burst request
  input  wire  rtg_pkg::addr_t mem_addr,   // CPU-mapped byte address
  output logic                 mem_fill,   // One strobe per returned word
  output rtg_pkg::word_t       mem_data
);

  localparam int LATENCY = 3;              // Cycles from request to first fill

  rtg_pkg::addr_t req_q[$];                // Every request address seen on the port
  rtg_pkg::addr_t req_lin;                 // Linear address of current burst

  // Bit-23 flip is its own inverse
  function automatic rtg_pkg::addr_t linear_addr(input rtg_pkg::addr_t a);
    rtg_pkg::addr_t l;
    l     = a;
    l[23] = a[23] ^ (a[22] | a[21]);
    return l;
  endfunction

  // Pattern from the word address
  function automatic rtg_pkg::word_t word_at(input rtg_pkg::addr_t byte_addr);
    rtg_pkg::addr_t w;
    w = byte_addr >> 1;
    return w[15:0] ^ 16'h5A5A;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Request service, one burst at a time
  //////////////////////////////////////////////////////////////////////

  initial begin
    mem_fill = 1'b0;
    mem_data = '0;
    forever begin
      @(negedge clk_114);                  // Port outputs are stable here
      if (arst_n && mem_req) begin
        req_q.push_back(mem_addr);
        req_lin = linear_addr(mem_addr);
        repeat (LATENCY) @(negedge clk_114);
        for (int k = 0; k < rtg_pkg::BURST_LEN; k++) begin
          mem_fill = 1'b1;
          mem_data = word_at(req_lin + rtg_pkg::addr_t'(2 * k));  // Little-endian words
          @(negedge clk_114);
        end
        mem_fill = 1'b0;
        mem_data = '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/rtg_video_tb.sv
// RTG video path testbench
`timescale 1ns/1ns
`default_nettype none

module rtg_video_tb;

  localparam int CLK_PERIOD    = 20;
  localparam int PIX_CLKS      = 4;                   // pixel_width 3
  localparam int STREAM_PIXELS = 24;                  // Crosses several refills
  localparam int RESET_CYC     = 8;                   // Cycle budgets per test
  localparam int NATIVE_CYC    = 24;
  localparam int OSD_CYC       = 12;
  localparam int FETCH_CYC     = 150;
  localparam int STREAM_CYC    = 4 + PIX_CLKS * STREAM_PIXELS;
  localparam int BLANK_CYC     = 90;
  localparam int WATCHDOG_CYC  = RESET_CYC + NATIVE_CYC + OSD_CYC + FETCH_CYC
                               + STREAM_CYC + BLANK_CYC + 200;
  localparam logic [7:0] NATIVE_MARK = 8'h01;         // Never an expanded channel

  logic clk_114, arst_n, rtg_ena, hblank, vblank;
  logic native_hs, native_vs, osd_window, osd_pixel;
  rtg_pkg::addr_t   base_addr, mem_addr;
  rtg_pkg::pixcnt_t pixel_width;
  rtg_pkg::vbcnt_t  vb_end;
  rtg_pkg::color_t  native_r, native_g, native_b;
  rtg_pkg::color_t  vga_r, vga_g, vga_b;
  logic             vga_hs, vga_vs, mem_req, mem_fill;
  rtg_pkg::word_t   mem_data;

  int             errors      = 0;
  int             checks      = 0;
  int             test_errors = 0;
  int             fill_count  = 0;                    // Every mem_fill seen
  int             frame_fills = 0;                    // fill_count when frame began
  logic [31:0]    lcg_state   = 32'd2;
  rtg_pkg::addr_t frame_lin;                          // Aligned linear frame start

  rtg_video_top rtg_video_top_i (
    .clk_114(clk_114), .arst_n(arst_n), .rtg_ena(rtg_ena), .base_addr(base_addr),
    .pixel_width(pixel_width), .vb_end(vb_end), .hblank(hblank), .vblank(vblank),
    .native_hs(native_hs), .native_vs(native_vs), .native_r(native_r),
    .native_g(native_g), .native_b(native_b), .osd_window(osd_window),
    .osd_pixel(osd_pixel), .mem_fill(mem_fill), .mem_data(mem_data),
    .mem_req(mem_req), .mem_addr(mem_addr), .vga_r(vga_r), .vga_g(vga_g),
    .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
  );

  rtg_mem_model mem_model_i (
    .clk_114(clk_114), .arst_n(arst_n), .mem_req(mem_req), .mem_addr(mem_addr),
    .mem_fill(mem_fill), .mem_data(mem_data)
  );

  always #(CLK_PERIOD / 2) clk_114 = ~clk_114;

  always @(posedge clk_114) begin
    if (mem_fill) begin
      fill_count <= fill_count + 1;                   // Words handed to the fetch engine
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // CPU map, bit 23 flips when bit 22 or 21 is set
  function automatic rtg_pkg::addr_t cpu_addr(input rtg_pkg::addr_t a);
    rtg_pkg::addr_t m;
    m     = a;
    m[23] = a[23] ^ (a[22] | a[21]);
    return m;
  endfunction

  function automatic rtg_pkg::color_t widen5(input logic [4:0] c);
    return {c, c[4:2]};                               // Top three bits fill the bottom
  endfunction

  // Memory word i of the current frame
  function automatic rtg_pkg::word_t frame_word(input int i);
    rtg_pkg::addr_t a;
    a = (frame_lin >> 1) + rtg_pkg::addr_t'(i);
    return a[15:0] ^ 16'h5A5A;
  endfunction

  task automatic expect_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got %h expected %h at %0t ns", sig, got, exp, $time);
      errors++;
      test_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic expect_color(input rtg_pkg::color_t r, input rtg_pkg::color_t g,
                              input rtg_pkg::color_t b);
    expect_val("vga_r", vga_r, r);
    expect_val("vga_g", vga_g, g);
    expect_val("vga_b", vga_b, b);
  endtask

  task automatic expect_word(input rtg_pkg::word_t w);
    expect_color(widen5(w[14:10]), widen5(w[9:5]), widen5(w[4:0]));  // RGB555
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s, %0d errors", name, (test_errors == 0) ? "pass" : "fail", test_errors);
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    {native_r, native_g, native_b} = {8'hFF, 8'hFF, 8'hFF};  // Would leak through unreset
    {native_hs, native_vs} = 2'b11;
    rtg_ena = 1'b1;                                   // Would request if not held
    for (int c = 0; c < 6; c++) begin
      @(negedge clk_114);
      expect_val("mem_req", mem_req, 0);
      expect_color(8'h00, 8'h00, 8'h00);
      expect_val("vga_hs", vga_hs, 0);
      expect_val("vga_vs", vga_vs, 0);
      if (c == 3) begin
        arst_n = 1'b1;                                // Held for four cycles
        {native_r, native_g, native_b} = '0;
        {native_hs, native_vs} = 2'b00;
        rtg_ena = 1'b0;
      end
    end
    finish_test("reset");
  endtask

  task automatic native_passthrough();
    logic [31:0]     r;
    rtg_pkg::color_t pr, pg, pb;
    logic            phs, pvs;
    rtg_ena    = 1'b0;
    osd_window = 1'b0;
    {pr, pg, pb, phs, pvs} = {native_r, native_g, native_b, native_hs, native_vs};
    for (int c = 0; c < 20; c++) begin
      @(negedge clk_114);
      expect_color(pr, pg, pb);                       // Inputs of previous cycle
      expect_val("vga_hs", vga_hs, phs);
      expect_val("vga_vs", vga_vs, pvs);
      expect_val("mem_req", mem_req, 0);
      r = lcg_next();
      {native_r, native_g, native_b} = r[31:8];
      r = lcg_next();
      {native_hs, native_vs} = r[31:30];
      {pr, pg, pb, phs, pvs} = {native_r, native_g, native_b, native_hs, native_vs};
    end
    finish_test("native passthrough");
  endtask

  task automatic osd_overlay();
    logic [31:0]     r;
    rtg_pkg::color_t pr, pg, pb;
    logic            pp;
    osd_window = 1'b1;
    for (int c = 0; c < 10; c++) begin
      @(negedge clk_114);
      if (c > 0) begin
        expect_color({(pp ? 2'b11 : 2'b00), pr[7:2]},   // Text white, box dark blue
                     {(pp ? 2'b11 : 2'b00), pg[7:2]},
                     {(pp ? 2'b11 : 2'b10), pb[7:2]});
      end
      r = lcg_next();
      {native_r, native_g, native_b} = r[31:8];
      osd_pixel = c[0];                               // Both pixel values
      {pr, pg, pb, pp} = {native_r, native_g, native_b, osd_pixel};
    end
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    finish_test("osd overlay");
  endtask

  task automatic fetch_addresses();
    logic [31:0]    r;
    rtg_pkg::addr_t base;
    int             first_req;
    int             waited;
    r = lcg_next();
    base = r[31:7];
    base[21] = 1'b1;                                  // Forces the bit-23 flip
    if (base[3:0] == 4'h0) begin
      base[3:0] = 4'h9;
    end
    frame_lin = {base[24:4], 4'h0};
    {native_r, native_g, native_b} = {3{NATIVE_MARK}};
    {native_hs, native_vs} = 2'b00;
    hblank      = 1'b1;                               // Nothing popped yet
    vb_end      = '0;
    pixel_width = rtg_pkg::pixcnt_t'(PIX_CLKS - 1);
    base_addr   = base;
    vblank      = 1'b1;
    rtg_ena     = 1'b1;
    repeat (4) @(negedge clk_114);
    first_req   = mem_model_i.req_q.size();
    frame_fills = fill_count;
    vblank      = 1'b0;
    waited      = 0;
    while (mem_model_i.req_q.size() < first_req + 4 && waited < 100) begin
      @(negedge clk_114);
      waited++;
    end
    expect_true(mem_model_i.req_q.size() >= first_req + 4,
                "fetch engine issued fewer than four bursts after vblank");
    repeat (30) begin
      @(negedge clk_114);
      expect_true(fill_count - frame_fills <= rtg_pkg::FIFO_DEPTH,
                  "more words fetched than the FIFO can hold with no pops");
    end
    expect_val("request count", mem_model_i.req_q.size() - first_req, 4);  // FIFO full
    for (int i = 0; i < 4; i++) begin
      if (first_req + i < mem_model_i.req_q.size()) begin
        expect_val("mem_addr", mem_model_i.req_q[first_req + i],
                   cpu_addr(frame_lin + rtg_pkg::addr_t'(rtg_pkg::BURST_BYTES * i)));
      end
    end
    finish_test("fetch addresses");
  endtask

  task automatic pixel_stream();
    int pops;
    hblank = 1'b0;
    for (int c = 0; c < 4 + PIX_CLKS * STREAM_PIXELS; c++) begin
      @(negedge clk_114);
      pops = (c >= PIX_CLKS - 1) ? (c - PIX_CLKS + 1) / PIX_CLKS + 1 : 0;
      expect_true(fill_count - frame_fills - pops <= rtg_pkg::FIFO_DEPTH,
                  "more than 16 fetched words left unread");
      if (c < 2) begin
        expect_color(NATIVE_MARK, NATIVE_MARK, NATIVE_MARK);  // Two-cycle blank delay
      end else if (c < 4) begin
        expect_true(vga_r != NATIVE_MARK, "native colour shown after blank ended");
      end else begin
        expect_word(frame_word((c - 4) / PIX_CLKS));  // Each word for PIX_CLKS cycles
      end
    end
    finish_test("pixel stream");
  endtask

  task automatic blank_extension();
    rtg_pkg::word_t w0;
    logic           seen;
    int             waited;
    vb_end    = 7'd3;
    native_hs = 1'b0;
    vblank    = 1'b1;                                 // Flushes and rewinds the frame
    repeat (10) @(negedge clk_114);
    vblank = 1'b0;
    for (int e = 1; e <= 3; e++) begin
      repeat (12) begin
        @(negedge clk_114);
        expect_color(NATIVE_MARK, NATIVE_MARK, NATIVE_MARK);
      end
      native_hs = 1'b1;                               // Rising edge e of hsync
      if (e < 3) begin
        repeat (4) begin
          @(negedge clk_114);
          expect_color(NATIVE_MARK, NATIVE_MARK, NATIVE_MARK);
        end
        native_hs = 1'b0;
      end
    end
    w0     = frame_word(0);
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < 20) begin
      @(negedge clk_114);
      waited++;
      seen = (vga_r == widen5(w0[14:10])) && (vga_g == widen5(w0[9:5]))
          && (vga_b == widen5(w0[4:0]));
    end
    native_hs = 1'b0;
    expect_true(seen, "first RTG pixel missing after the third hsync edge");
    repeat (PIX_CLKS - 1) begin
      @(negedge clk_114);
      expect_word(w0);
    end
    @(negedge clk_114);
    expect_word(frame_word(1));
    finish_test("blank extension");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_114     = 1'b0;
    arst_n      = 1'b0;
    rtg_ena     = 1'b0;
    base_addr   = '0;
    pixel_width = '0;
    vb_end      = '0;
    hblank      = 1'b0;
    vblank      = 1'b0;
    native_hs   = 1'b0;
    native_vs   = 1'b0;
    native_r    = '0;
    native_g    = '0;
    native_b    = '0;
    osd_window  = 1'b0;
    osd_pixel   = 1'b0;
    reset_values();
    native_passthrough();
    osd_overlay();
    fetch_addresses();
    pixel_stream();
    blank_extension();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, simulation stuck", WATCHDOG_CYC);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/rtg_pkg.sv
hw/rtg_stream_if.sv
hw/rtg_fetch.sv
hw/rtg_line_fifo.sv
hw/rtg_pixel_out.sv
hw/rtg_video_top.sv
dv/rtg_mem_model.sv
dv/rtg_video_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the RTG video testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module rtg_video_tb -o rtg_video_sim \
  && ./obj_dir/rtg_video_sim | tee /dev/stderr | grep -qx "Test OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
